//--- Makefile
VERILATOR ?= verilator
TOP       ?= ppi_tb
RTL_TOP   ?= ppi_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+hw
+incdir+sim
hw/ppi_pkg.sv
hw/ppi_bus_ctrl.sv
hw/ppi_mode_ctrl.sv
hw/ppi_port.sv
hw/ppi_port_c.sv
hw/ppi_top.sv
sim/ppi_clkgen.sv
sim/ppi_tb.sv

//--- hw/ppi_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppi_macros.svh"

module ppi_bus_ctrl (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    chip_select,
    input  logic                    read_enable,
    input  logic                    write_enable,
    input  ppi_pkg::ppi_addr_e      address,
    input  logic [`PPI_DATA_W-1:0]  data_bus_in,
    output logic                    ack,
    output ppi_pkg::ppi_access_t    access
);

    import ppi_pkg::*;

    logic        req;
    logic        req_q;
    logic        new_req;
    ppi_access_t access_d;

    assign req     = chip_select & (read_enable | write_enable);
    // Only the rising edge of a request is acknowledged
    assign new_req = req & ~req_q;

    always_comb begin
        access_d       = '0;
        access_d.wdata = data_bus_in;
        if (new_req) begin
            if (write_enable) begin
                case (address)
                    PPI_ADDR_A: access_d.wr_a    = 1'b1;
                    PPI_ADDR_B: access_d.wr_b    = 1'b1;
                    PPI_ADDR_C: access_d.wr_c    = 1'b1;
                    default:    access_d.wr_ctrl = 1'b1;
                endcase
            end else begin
                // Control register reads back as zero
                case (address)
                    PPI_ADDR_A: access_d.rd_a = 1'b1;
                    PPI_ADDR_B: access_d.rd_b = 1'b1;
                    PPI_ADDR_C: access_d.rd_c = 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            req_q  <= 1'b0;
            ack    <= 1'b0;
            access <= '0;
        end else begin
            req_q  <= req;
            ack    <= new_req;
            access <= access_d;
        end
    end

    a_ack_single: assert property (
        @(posedge clock) disable iff (!arst_n) ack |=> !ack
    );

    a_wr_onehot: assert property (
        @(posedge clock) disable iff (!arst_n)
        $onehot0({access.wr_a, access.wr_b, access.wr_c, access.wr_ctrl})
    );

endmodule

`default_nettype wire

//--- hw/ppi_macros.svh
`ifndef PPI_MACROS_SVH
`define PPI_MACROS_SVH

// Data bus and port width
`define PPI_DATA_W      8

// Register address width for four registers
`define PPI_ADDR_W      2

// Direction flag after reset where a one means input
`define PPI_DIR_RESET   1'b1

`endif

//--- hw/ppi_mode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppi_macros.svh"

module ppi_mode_ctrl (
    input  logic                    clock,
    input  logic                    arst_n,
    input  ppi_pkg::ppi_access_t    access,
    output ppi_pkg::ppi_ctrl_t      ctrl,
    output logic                    mode_update,
    output ppi_pkg::ppi_bsr_t       bsr
);

    import ppi_pkg::*;

    localparam ppi_ctrl_t CTRL_RESET = '{
        group_a_mode: 2'b00,
        port_a_io:    `PPI_DIR_RESET,
        port_c_hi_io: `PPI_DIR_RESET,
        group_b_mode: 1'b0,
        port_b_io:    `PPI_DIR_RESET,
        port_c_lo_io: `PPI_DIR_RESET
    };

    logic mode_write;

    // Bit 7 selects mode word or port C bit set/reset
    assign mode_write = access.wr_ctrl & access.wdata[7];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl        <= CTRL_RESET;
            mode_update <= 1'b0;
        end else begin
            if (mode_write) begin
                ctrl <= ppi_ctrl_t'(access.wdata[6:0]);
            end
            mode_update <= mode_write;
        end
    end

    // Acts in the ack cycle so the bit lands with the other writes
    assign bsr.valid = access.wr_ctrl & ~access.wdata[7];
    assign bsr.index = access.wdata[3:1];
    assign bsr.value = access.wdata[0];

    a_update_vs_bsr: assert property (
        @(posedge clock) disable iff (!arst_n) !(mode_update && bsr.valid)
    );

endmodule

`default_nettype wire

//--- hw/ppi_pkg.sv
`default_nettype none

`include "ppi_macros.svh"

package ppi_pkg;

    // Register map
    typedef enum logic [`PPI_ADDR_W-1:0] {
        PPI_ADDR_A,
        PPI_ADDR_B,
        PPI_ADDR_C,
        PPI_ADDR_CTRL
    } ppi_addr_e;

    // One decoded bus access, valid in the ack cycle
    typedef struct packed {
        logic [`PPI_DATA_W-1:0] wdata;
        logic                   wr_a;
        logic                   wr_b;
        logic                   wr_c;
        logic                   wr_ctrl;
        logic                   rd_a;
        logic                   rd_b;
        logic                   rd_c;
    } ppi_access_t;

    // Field order follows control word bits 6 down to 0
    typedef struct packed {
        logic [1:0] group_a_mode;
        logic       port_a_io;
        logic       port_c_hi_io;
        logic       group_b_mode;
        logic       port_b_io;
        logic       port_c_lo_io;
    } ppi_ctrl_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] index;
        logic       value;
    } ppi_bsr_t;

    // A one in io marks an input bit
    typedef struct packed {
        logic [`PPI_DATA_W-1:0] data;
        logic [`PPI_DATA_W-1:0] io;
    } ppi_pins_t;

endpackage

`default_nettype wire

//--- hw/ppi_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppi_macros.svh"

module ppi_port (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    wr,
    input  logic [`PPI_DATA_W-1:0]  wdata,
    input  logic                    is_input,
    input  logic                    mode_update,
    input  logic [`PPI_DATA_W-1:0]  pin_in,
    output ppi_pkg::ppi_pins_t      pins,
    output logic [`PPI_DATA_W-1:0]  rdata
);

    import ppi_pkg::*;

    logic [`PPI_DATA_W-1:0] latch;

    // New mode word clears the latch
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            latch <= '0;
        end else if (mode_update) begin
            latch <= '0;
        end else if (wr) begin
            latch <= wdata;
        end
    end

    assign pins.data = latch;
    assign pins.io   = {`PPI_DATA_W{is_input}};

    // Inputs read the pins, outputs read back the latch
    assign rdata = is_input ? pin_in : latch;

endmodule

`default_nettype wire

//--- hw/ppi_port_c.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppi_macros.svh"

module ppi_port_c (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    wr,
    input  logic [`PPI_DATA_W-1:0]  wdata,
    input  ppi_pkg::ppi_ctrl_t      ctrl,
    input  logic                    mode_update,
    input  ppi_pkg::ppi_bsr_t       bsr,
    input  logic [`PPI_DATA_W-1:0]  pin_in,
    output ppi_pkg::ppi_pins_t      pins,
    output logic [`PPI_DATA_W-1:0]  rdata
);

    import ppi_pkg::*;

    localparam int NIB_W = `PPI_DATA_W / 2;

    logic [`PPI_DATA_W-1:0] latch;
    logic [`PPI_DATA_W-1:0] dir_in;

    // Upper nibble follows group A, lower nibble group B
    assign dir_in = {{NIB_W{ctrl.port_c_hi_io}}, {NIB_W{ctrl.port_c_lo_io}}};

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            latch <= '0;
        end else if (mode_update) begin
            latch <= '0;
        end else if (wr) begin
            latch <= wdata;
        end else if (bsr.valid) begin
            latch[bsr.index] <= bsr.value;
        end
    end

    assign pins.data = latch;
    assign pins.io   = dir_in;

    // Read-back picked bit by bit
    assign rdata = (pin_in & dir_in) | (latch & ~dir_in);

    // Port C write and control write come from different addresses
    a_wr_vs_bsr: assert property (
        @(posedge clock) disable iff (!arst_n) !(wr && bsr.valid)
    );

endmodule

`default_nettype wire

//--- hw/ppi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppi_macros.svh"

module ppi_top (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    chip_select,
    input  logic                    read_enable,
    input  logic                    write_enable,
    input  ppi_pkg::ppi_addr_e      address,
    input  logic [`PPI_DATA_W-1:0]  data_bus_in,
    output logic [`PPI_DATA_W-1:0]  data_bus_out,
    output logic                    ack,
    input  logic [`PPI_DATA_W-1:0]  port_a_in,
    input  logic [`PPI_DATA_W-1:0]  port_b_in,
    input  logic [`PPI_DATA_W-1:0]  port_c_in,
    output ppi_pkg::ppi_pins_t      port_a,
    output ppi_pkg::ppi_pins_t      port_b,
    output ppi_pkg::ppi_pins_t      port_c
);

    import ppi_pkg::*;

    ppi_access_t            access;
    ppi_ctrl_t              ctrl;
    ppi_bsr_t               bsr;
    logic                   mode_update;
    logic [`PPI_DATA_W-1:0] port_a_rdata;
    logic [`PPI_DATA_W-1:0] port_b_rdata;
    logic [`PPI_DATA_W-1:0] port_c_rdata;

    ppi_bus_ctrl u_bus_ctrl (
        .clock        (clock),
        .arst_n       (arst_n),
        .chip_select  (chip_select),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .address      (address),
        .data_bus_in  (data_bus_in),
        .ack          (ack),
        .access       (access)
    );

    ppi_mode_ctrl u_mode_ctrl (
        .clock       (clock),
        .arst_n      (arst_n),
        .access      (access),
        .ctrl        (ctrl),
        .mode_update (mode_update),
        .bsr         (bsr)
    );

    ppi_port u_port_a (
        .clock       (clock),
        .arst_n      (arst_n),
        .wr          (access.wr_a),
        .wdata       (access.wdata),
        .is_input    (ctrl.port_a_io),
        .mode_update (mode_update),
        .pin_in      (port_a_in),
        .pins        (port_a),
        .rdata       (port_a_rdata)
    );

    ppi_port u_port_b (
        .clock       (clock),
        .arst_n      (arst_n),
        .wr          (access.wr_b),
        .wdata       (access.wdata),
        .is_input    (ctrl.port_b_io),
        .mode_update (mode_update),
        .pin_in      (port_b_in),
        .pins        (port_b),
        .rdata       (port_b_rdata)
    );

    ppi_port_c u_port_c (
        .clock       (clock),
        .arst_n      (arst_n),
        .wr          (access.wr_c),
        .wdata       (access.wdata),
        .ctrl        (ctrl),
        .mode_update (mode_update),
        .bsr         (bsr),
        .pin_in      (port_c_in),
        .pins        (port_c),
        .rdata       (port_c_rdata)
    );

    // Read selects only live in the ack cycle, so the bus idles at zero
    always_comb begin
        data_bus_out = '0;
        if (access.rd_a) begin
            data_bus_out = port_a_rdata;
        end else if (access.rd_b) begin
            data_bus_out = port_b_rdata;
        end else if (access.rd_c) begin
            data_bus_out = port_c_rdata;
        end
    end

    a_bus_idle_zero: assert property (
        @(posedge clock) disable iff (!arst_n) !ack |-> (data_bus_out == '0)
    );

endmodule

`default_nettype wire

//--- sim/ppi_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module ppi_clkgen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        // Release between edges
        #1;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/ppi_tb_tasks.svh
`ifndef PPI_TB_TASKS_SVH
`define PPI_TB_TASKS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Expected read data from the model of control word, latches and pins
function automatic logic [`PPI_DATA_W-1:0] ppi_model_read(input ppi_addr_e addr);
    logic [3:0] hi;
    logic [3:0] lo;
    hi = m_ctrl.port_c_hi_io ? port_c_in[7:4] : m_c[7:4];
    lo = m_ctrl.port_c_lo_io ? port_c_in[3:0] : m_c[3:0];
    case (addr)
        PPI_ADDR_A: return m_ctrl.port_a_io ? port_a_in : m_a;
        PPI_ADDR_B: return m_ctrl.port_b_io ? port_b_in : m_b;
        PPI_ADDR_C: return {hi, lo};
        default:    return '0;
    endcase
endfunction

function automatic ppi_pins_t ppi_model_pins(input ppi_addr_e addr);
    ppi_pins_t p;
    p = '0;
    case (addr)
        PPI_ADDR_A: p = '{data: m_a, io: m_ctrl.port_a_io ? 8'hff : 8'h00};
        PPI_ADDR_B: p = '{data: m_b, io: m_ctrl.port_b_io ? 8'hff : 8'h00};
        default: begin
            p.data    = m_c;
            p.io[7:4] = m_ctrl.port_c_hi_io ? 4'hf : 4'h0;
            p.io[3:0] = m_ctrl.port_c_lo_io ? 4'hf : 4'h0;
        end
    endcase
    return p;
endfunction

function automatic void model_write(input ppi_addr_e addr, input logic [7:0] d);
    case (addr)
        PPI_ADDR_A: m_a = d;
        PPI_ADDR_B: m_b = d;
        PPI_ADDR_C: m_c = d;
        default: begin
            if (d[7]) begin
                // New mode word clears every latch
                m_ctrl = ppi_ctrl_t'(d[6:0]);
                m_a    = '0;
                m_b    = '0;
                m_c    = '0;
            end else begin
                m_c[d[3:1]] = d[0];
            end
        end
    endcase
endfunction

task automatic check_data(input string what, input logic [`PPI_DATA_W-1:0] got,
                          input logic [`PPI_DATA_W-1:0] exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        errors++;
        test_errors++;
    end
endtask

task automatic check_pins(input string what, input ppi_pins_t got, input ppi_pins_t exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s got data %h io %h expected data %h io %h",
                 $time, what, got.data, got.io, exp.data, exp.io);
        errors++;
        test_errors++;
    end
endtask

task automatic check_ack(input string what, input int acks);
    if (acks != 1) begin
        $display("Request to %s saw %0d acknowledges instead of one", what, acks);
        errors++;
        test_errors++;
    end
endtask

`endif

//--- sim/ppi_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppi_macros.svh"

module ppi_tb;

    import ppi_pkg::*;

    localparam int ACK_TIMEOUT   = 20;
    localparam int RESET_TIMEOUT = 40;

    logic                   clock;
    logic                   arst_n;
    logic                   chip_select;
    logic                   read_enable;
    logic                   write_enable;
    ppi_addr_e              address;
    logic [`PPI_DATA_W-1:0] data_bus_in;
    logic [`PPI_DATA_W-1:0] data_bus_out;
    logic                   ack;
    logic [`PPI_DATA_W-1:0] port_a_in, port_b_in, port_c_in;
    ppi_pins_t              port_a, port_b, port_c;

    ppi_ctrl_t              m_ctrl;
    logic [`PPI_DATA_W-1:0] m_a, m_b, m_c;
    logic [31:0]            rng;
    int                     errors, test_errors, test_num, tests_failed;

    `include "ppi_tb_tasks.svh"

    ppi_clkgen #(.HALF_PERIOD(2), .RESET_CYCLES(8)) u_clkgen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    ppi_top u_dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .chip_select  (chip_select),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .address      (address),
        .data_bus_in  (data_bus_in),
        .data_bus_out (data_bus_out),
        .ack          (ack),
        .port_a_in    (port_a_in),
        .port_b_in    (port_b_in),
        .port_c_in    (port_c_in),
        .port_a       (port_a),
        .port_b       (port_b),
        .port_c       (port_c)
    );

    // Bus idles at zero outside ack
    always @(negedge clock) begin
        if (arst_n === 1'b1 && ack !== 1'b1) begin
            check_data("idle data_bus_out", data_bus_out, '0);
        end
    end

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic abort_run(input string why);
        $display("Run aborted: %s", why);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %0d errors", test_num, name, test_errors);
        test_errors = 0;
    endtask

    // Holds the request hold cycles past ack, then idles two cycles
    task automatic bus_access(input logic is_write, input ppi_addr_e addr,
                              input logic [7:0] wdata, input int hold,
                              output logic [7:0] rdata);
        int wait_cycles;
        int acks;
        chip_select  = 1'b1;
        read_enable  = !is_write;
        write_enable = is_write;
        address      = addr;
        data_bus_in  = wdata;
        wait_cycles  = 0;
        do begin
            @(negedge clock);
            wait_cycles++;
        end while (ack !== 1'b1 && wait_cycles < ACK_TIMEOUT);
        if (ack !== 1'b1) begin
            abort_run({"no acknowledge for a request to ", addr.name()});
        end
        rdata = data_bus_out;
        acks  = 1;
        for (int i = 0; i < hold + 2; i++) begin
            if (i == hold) begin
                chip_select  = 1'b0;
                read_enable  = 1'b0;
                write_enable = 1'b0;
            end
            @(negedge clock);
            if (ack === 1'b1) begin
                acks++;
            end
        end
        check_ack(addr.name(), acks);
    endtask

    task automatic write_reg(input ppi_addr_e addr, input logic [7:0] d, input int hold);
        logic [7:0] unused_rdata;
        bus_access(1'b1, addr, d, hold, unused_rdata);
        model_write(addr, d);
    endtask

    task automatic read_check(input ppi_addr_e addr, input int hold);
        logic [7:0] r;
        bus_access(1'b0, addr, 8'h00, hold, r);
        check_data({"read ", addr.name()}, r, ppi_model_read(addr));
    endtask

    task automatic drive_pins();
        logic [31:0] r;
        r         = next_rand();
        port_a_in = r[7:0];
        port_b_in = r[15:8];
        port_c_in = r[23:16];
    endtask

    task automatic check_ports();
        check_pins("port A pins", port_a, ppi_model_pins(PPI_ADDR_A));
        check_pins("port B pins", port_b, ppi_model_pins(PPI_ADDR_B));
        check_pins("port C pins", port_c, ppi_model_pins(PPI_ADDR_C));
        read_check(PPI_ADDR_A, 0);
        read_check(PPI_ADDR_B, 0);
        read_check(PPI_ADDR_C, 0);
    endtask

    initial begin
        int          wait_cycles;
        logic [31:0] r;
        chip_select  = 1'b0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        address      = PPI_ADDR_A;
        data_bus_in  = '0;
        port_a_in    = '0;
        port_b_in    = '0;
        port_c_in    = '0;
        // All ports input, all modes zero
        m_ctrl       = ppi_ctrl_t'(7'b001_1011);
        m_a          = '0;
        m_b          = '0;
        m_c          = '0;
        rng          = 32'h3863_0d39;
        errors       = 0;
        test_errors  = 0;
        test_num     = 0;
        tests_failed = 0;
        wait_cycles  = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clock);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                abort_run("reset was never released");
            end
        end

        drive_pins();
        check_ports();
        end_test("reset state");

        repeat (10) begin
            r = next_rand();
            write_reg(PPI_ADDR_CTRL, {1'b1, r[6:0]}, 0);
            drive_pins();
            write_reg(PPI_ADDR_A, r[15:8], 0);
            write_reg(PPI_ADDR_B, r[23:16], 0);
            write_reg(PPI_ADDR_C, r[31:24], 0);
            check_ports();
        end
        end_test("random modes and writes");

        r = next_rand();
        write_reg(PPI_ADDR_CTRL, {1'b1, r[6:0]}, 0);
        write_reg(PPI_ADDR_C, r[15:8], 0);
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            write_reg(PPI_ADDR_CTRL, {4'b0000, i[2:0], r[0]}, 0);
            check_ports();
        end
        end_test("port C bit set/reset");

        write_reg(PPI_ADDR_CTRL, 8'h80, 0);
        write_reg(PPI_ADDR_A, 8'h5a, 0);
        write_reg(PPI_ADDR_B, 8'ha5, 0);
        write_reg(PPI_ADDR_C, 8'h3c, 0);
        check_ports();
        r = next_rand();
        write_reg(PPI_ADDR_CTRL, {1'b1, r[6:0]}, 0);
        check_data("port A latch after mode write", port_a.data, '0);
        check_data("port B latch after mode write", port_b.data, '0);
        check_data("port C latch after mode write", port_c.data, '0);
        check_ports();
        end_test("mode write clears latches");

        drive_pins();
        read_check(PPI_ADDR_A, 5);
        write_reg(PPI_ADDR_B, 8'h77, 4);
        read_check(PPI_ADDR_CTRL, 3);
        check_ports();
        end_test("acknowledge and control read");

        $display("Tests: %0d, failed: %0d, errors: %0d", test_num, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
